// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = gather_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/clk_gen.sv
// Testbench clock and reset

`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 16,
    parameter int SKEW_NS    = 10
) (
    output logic clk,
    output logic srst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lands just after an edge, like the other inputs
    initial begin
        srst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #(SKEW_NS);
        srst = 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/gather_tb.sv
// Packet gather testbench

`timescale 1ns/100ps
`default_nettype none

module gather_tb;

    localparam logic [31:0] SEED       = 32'h2f9929a2;
    localparam int          CLK_NS     = 100;
    localparam int          SKEW_NS    = 10;
    localparam int          N_BP_PKTS  = 4;
    localparam int          N_STREAM   = 20;
    localparam int          N_PACKETS  = 3 + N_BP_PKTS + N_STREAM;
    localparam int          TIMEOUT_NS = (N_PACKETS * 200 + 2000) * CLK_NS;
    localparam int          SETTLE_CYC = 16;

    logic                                 clk;
    logic                                 srst;
    logic                                 desc_vld;
    gather_pkg::desc_t                    desc;
    logic                                 desc_rdy;
    logic                                 link_wr;
    logic [gather_pkg::PTR_WID-1:0]       link_ptr;
    logic [gather_pkg::PTR_WID-1:0]       link_nxt;
    logic                                 mem_wr;
    logic [gather_pkg::ADDR_WID-1:0]      mem_wr_addr;
    logic [gather_pkg::DATA_WID-1:0]      mem_wr_data;
    logic                                 pkt_vld;
    gather_pkg::pkt_word_t                pkt;
    logic                                 pkt_rdy;
    logic                                 evt;
    gather_pkg::pkt_event_t               evt_info;

    // Model state
    logic [gather_pkg::DATA_WID-1:0]      mem_img  [2**gather_pkg::ADDR_WID];
    logic [gather_pkg::PTR_WID-1:0]       link_img [gather_pkg::NUM_BUFFERS];
    gather_pkg::pkt_word_t                exp_words [$];
    gather_pkg::pkt_event_t               exp_evts [$];

    logic                                 rand_rdy;
    int                                   errors;
    int                                   err_mark;
    int                                   words_seen;
    int                                   evts_seen;
    int                                   tests_run;
    int                                   tests_failed;

    clk_gen #(
        .PERIOD_NS  (CLK_NS),
        .RST_CYCLES (16),
        .SKEW_NS    (SKEW_NS)
    ) i_clk_gen (
        .clk  (clk),
        .srst (srst)
    );

    gather_top uut (
        .clk         (clk),
        .srst        (srst),
        .desc_vld    (desc_vld),
        .desc        (desc),
        .desc_rdy    (desc_rdy),
        .link_wr     (link_wr),
        .link_ptr    (link_ptr),
        .link_nxt    (link_nxt),
        .mem_wr      (mem_wr),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .pkt_vld     (pkt_vld),
        .pkt         (pkt),
        .pkt_rdy     (pkt_rdy),
        .evt         (evt),
        .evt_info    (evt_info)
    );

    // --------------------
    // Reporting
    // --------------------
    task automatic flag_mismatch(input string msg);
        errors++;
        $display("[FAIL] %0d ns: %s", $time, msg);
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic start_test();
        err_mark   = errors;
        words_seen = 0;
        evts_seen  = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("Test %0d PASS  %s", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d FAIL  %s, %0d errors", tests_run, name, errors - err_mark);
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    // Byte stream of the packet is the chain of buffers in link order
    function automatic void build_expected(
        input logic [gather_pkg::DATA_WID-1:0] img   [2**gather_pkg::ADDR_WID],
        input logic [gather_pkg::PTR_WID-1:0]  links [gather_pkg::NUM_BUFFERS],
        input gather_pkg::desc_t               d
    );
        int                             n_words;
        int                             tail;
        logic [gather_pkg::PTR_WID-1:0] bp;
        gather_pkg::pkt_word_t          w;
        gather_pkg::pkt_event_t         e;
        n_words = (int'(d.size) + gather_pkg::DATA_BYTES - 1) / gather_pkg::DATA_BYTES;
        tail    = int'(d.size) % gather_pkg::DATA_BYTES;
        bp      = d.ptr;
        for (int i = 0; i < n_words; i++) begin
            if (i > 0 && i % gather_pkg::BUFFER_WORDS == 0) begin
                bp = links[bp];
            end
            w.data = img[int'(bp) * gather_pkg::BUFFER_WORDS + i % gather_pkg::BUFFER_WORDS];
            w.eop  = (i == n_words - 1);
            w.mty  = '0;
            if (w.eop && tail != 0) begin
                w.mty = gather_pkg::MTY_WID'(gather_pkg::DATA_BYTES - tail);
            end
            w.meta = d.meta;
            exp_words.push_back(w);
        end
        e.meta = d.meta;
        e.size = d.size;
        exp_evts.push_back(e);
    endfunction

    // --------------------
    // Stimulus tasks, all entered just after a rising edge
    // --------------------
    task automatic load_memory();
        for (int a = 0; a < 2**gather_pkg::ADDR_WID; a++) begin
            mem_wr      = 1'b1;
            mem_wr_addr = gather_pkg::ADDR_WID'(a);
            mem_wr_data = {$urandom, $urandom};
            mem_img[a]  = mem_wr_data;
            @(posedge clk);
            #(SKEW_NS);
        end
        mem_wr = 1'b0;
    endtask

    task automatic wait_idle();
        while (!desc_rdy) begin
            @(posedge clk);
            #(SKEW_NS);
        end
    endtask

    task automatic write_link(input int from, input int to);
        link_wr        = 1'b1;
        link_ptr       = gather_pkg::PTR_WID'(from);
        link_nxt       = gather_pkg::PTR_WID'(to);
        link_img[from] = link_nxt;
        @(posedge clk);
        #(SKEW_NS);
        link_wr = 1'b0;
    endtask

    task automatic send_desc(input gather_pkg::desc_t d);
        wait_idle();
        desc_vld = 1'b1;
        desc     = d;
        @(posedge clk);
        #(SKEW_NS);
        desc_vld = 1'b0;
    endtask

    // Chains a random set of distinct buffers, then posts the descriptor
    task automatic issue_packet(input int size);
        int                order [gather_pkg::NUM_BUFFERS];
        int                n_bufs;
        int                j;
        int                tmp;
        gather_pkg::desc_t d;
        for (int i = 0; i < gather_pkg::NUM_BUFFERS; i++) begin
            order[i] = i;
        end
        for (int i = gather_pkg::NUM_BUFFERS - 1; i > 0; i--) begin
            j        = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        n_bufs = (size + 31) / 32;
        // The walker must be done with the old links first
        wait_idle();
        for (int i = 0; i < n_bufs - 1; i++) begin
            write_link(order[i], order[i+1]);
        end
        d.ptr  = gather_pkg::PTR_WID'(order[0]);
        d.size = gather_pkg::SIZE_WID'(size);
        d.meta = gather_pkg::META_WID'($urandom);
        build_expected(mem_img, link_img, d);
        send_desc(d);
    endtask

    task automatic wait_drain();
        while (exp_words.size() != 0 || exp_evts.size() != 0) begin
            @(posedge clk);
            #(SKEW_NS);
        end
        // Quiet period so a repeated trailing word or event is still counted
        repeat (SETTLE_CYC) begin
            @(posedge clk);
            #(SKEW_NS);
        end
    endtask

    task automatic check_count(input string what, input int got, input int want);
        if (got != want) begin
            flag_mismatch($sformatf("%s count %0d, expected %0d", what, got, want));
        end
    endtask

    // --------------------
    // Output back-pressure
    // --------------------
    initial begin
        pkt_rdy = 1'b1;
        forever begin
            @(posedge clk);
            #(SKEW_NS);
            if (rand_rdy) pkt_rdy = ($urandom % 2) == 0;
            else pkt_rdy = 1'b1;
        end
    end

    // --------------------
    // Compare, sampled mid-cycle where outputs are settled
    // --------------------
    always @(negedge clk) begin
        gather_pkg::pkt_word_t  exp_w;
        gather_pkg::pkt_event_t exp_e;
        if (!srst && pkt_vld && pkt_rdy) begin
            words_seen++;
            if (exp_words.size() == 0) begin
                flag_error("the DUT sent a packet word that no descriptor asked for");
            end else begin
                exp_w = exp_words.pop_front();
                if (pkt.data !== exp_w.data) begin
                    flag_mismatch($sformatf("data %h, expected %h", pkt.data, exp_w.data));
                end
                if (pkt.eop !== exp_w.eop) begin
                    flag_mismatch($sformatf("eop %b, expected %b", pkt.eop, exp_w.eop));
                end
                if (pkt.mty !== exp_w.mty) begin
                    flag_mismatch($sformatf("mty %0d, expected %0d", pkt.mty, exp_w.mty));
                end
                if (pkt.meta !== exp_w.meta) begin
                    flag_mismatch($sformatf("meta %h, expected %h", pkt.meta, exp_w.meta));
                end
            end
        end
        if (!srst && evt) begin
            evts_seen++;
            if (exp_evts.size() == 0) begin
                flag_error("the DUT raised an event with no packet outstanding");
            end else begin
                exp_e = exp_evts.pop_front();
                if (evt_info.meta !== exp_e.meta) begin
                    flag_mismatch($sformatf("event meta %h, expected %h",
                                            evt_info.meta, exp_e.meta));
                end
                if (evt_info.size !== exp_e.size) begin
                    flag_mismatch($sformatf("event size %0d, expected %0d",
                                            evt_info.size, exp_e.size));
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the DUT stopped delivering packets", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        void'($urandom(SEED));
        desc_vld     = 1'b0;
        desc         = '0;
        link_wr      = 1'b0;
        link_ptr     = '0;
        link_nxt     = '0;
        mem_wr       = 1'b0;
        mem_wr_addr  = '0;
        mem_wr_data  = '0;
        rand_rdy     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < gather_pkg::NUM_BUFFERS; i++) begin
            link_img[i] = '0;
        end

        @(negedge srst);
        if (!desc_rdy || pkt_vld || evt) begin
            flag_error("outputs are not in their reset state after reset");
        end
        load_memory();

        start_test();
        issue_packet(5);
        wait_drain();
        check_count("word", words_seen, 1);
        end_test("single 5-byte packet");

        start_test();
        issue_packet(70);
        wait_drain();
        check_count("word", words_seen, 9);
        end_test("70 bytes over three buffers");

        start_test();
        issue_packet(64);
        wait_drain();
        check_count("word", words_seen, 8);
        end_test("64 bytes ending on a buffer boundary");

        start_test();
        rand_rdy = 1'b1;
        for (int i = 0; i < N_BP_PKTS; i++) begin
            issue_packet(1 + int'($urandom % 200));
        end
        wait_drain();
        rand_rdy = 1'b0;
        check_count("event", evts_seen, N_BP_PKTS);
        end_test("random output back-pressure");

        start_test();
        for (int i = 0; i < N_STREAM; i++) begin
            issue_packet(1 + int'($urandom % 200));
        end
        wait_drain();
        check_count("event", evts_seen, N_STREAM);
        end_test("back-to-back random packets");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/buffer_chain.sv
// Buffer chain walker

`timescale 1ns/100ps
`default_nettype none

module buffer_chain (
    input  logic                             clk,
    input  logic                             srst,

    // Descriptor input
    input  logic                             desc_vld,
    input  gather_pkg::desc_t                desc,
    output logic                             desc_rdy,

    // Link table load
    input  logic                             link_wr,
    input  logic [gather_pkg::PTR_WID-1:0]   link_ptr,
    input  logic [gather_pkg::PTR_WID-1:0]   link_nxt,

    // Buffer hand-off to the gather engine
    output logic                             buf_wr,
    output gather_pkg::buffer_ctxt_t         buf_ctxt,
    input  logic                             buf_space
);

    logic [gather_pkg::PTR_WID-1:0]  link_mem [gather_pkg::NUM_BUFFERS];

    logic                            walking;
    logic                            desc_acc;
    logic                            last_buf;

    logic [gather_pkg::PTR_WID-1:0]  cur_ptr;
    logic [gather_pkg::SIZE_WID-1:0] remain;
    logic [gather_pkg::META_WID-1:0] cur_meta;

    // --------------------
    // Link table
    // --------------------
    always_ff @(posedge clk) begin
        if (link_wr) begin
            link_mem[link_ptr] <= link_nxt;
        end
    end

    // --------------------
    // Walker control
    // --------------------
    assign desc_rdy = !walking;
    assign desc_acc = desc_vld && desc_rdy;

    // 32 bytes or fewer left means this is the final buffer
    assign last_buf = (remain <= gather_pkg::BUFFER_WORDS * gather_pkg::DATA_BYTES);

    // Emit one buffer per cycle while the queue has room
    assign buf_wr = walking && buf_space;

    always_ff @(posedge clk) begin
        if (srst) begin
            walking <= 1'b0;
        end else if (desc_acc) begin
            walking <= 1'b1;
        end else if (buf_wr && last_buf) begin
            walking <= 1'b0;
        end
    end

    // --------------------
    // Current buffer
    // --------------------
    always_ff @(posedge clk) begin
        if (desc_acc) begin
            cur_ptr  <= desc.ptr;
            remain   <= desc.size;
            cur_meta <= desc.meta;
        end else if (buf_wr) begin
            cur_ptr <= link_mem[cur_ptr];
            remain  <= remain - gather_pkg::SIZE_WID'(
                gather_pkg::BUFFER_WORDS * gather_pkg::DATA_BYTES);
        end
    end

    // Size is the remainder modulo 32, zero when the last buffer is full
    assign buf_ctxt.ptr  = cur_ptr;
    assign buf_ctxt.eof  = last_buf;
    assign buf_ctxt.size = remain[gather_pkg::BUF_SIZE_WID-1:0];
    assign buf_ctxt.meta = cur_meta;

endmodule

`default_nettype wire

// File: source/fifo_sync.sv
// Synchronous FIFO, first-word fall-through

`timescale 1ns/100ps
`default_nettype none

module fifo_sync #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       srst,

    input  logic                       wr,
    input  logic [WIDTH-1:0]           wr_data,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] count,

    input  logic                       rd,
    output logic [WIDTH-1:0]           rd_data,
    output logic                       empty
);

    logic [WIDTH-1:0]         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic                     wr_en;
    logic                     rd_en;

    // Writes into a full FIFO and reads from an empty one are dropped
    assign wr_en = wr && !full;
    assign rd_en = rd && !empty;

    assign full  = (count == DEPTH);
    assign empty = (count == 0);

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head of queue is visible without a read
    assign rd_data = mem[rd_ptr];

    // --------------------
    // Pointers and fill count
    // --------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                if (wr_ptr == DEPTH - 1) wr_ptr <= '0;
                else wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                if (rd_ptr == DEPTH - 1) rd_ptr <= '0;
                else rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/gather_pkg.sv
// Packet gather shared definitions

`default_nettype none

package gather_pkg;

    // --------------------
    // Word and buffer geometry
    // --------------------
    localparam int DATA_BYTES   = 8;
    localparam int DATA_WID     = DATA_BYTES * 8;
    localparam int MTY_WID      = 3;
    localparam int BUFFER_WORDS = 4;
    localparam int NUM_BUFFERS  = 16;
    localparam int PTR_WID      = 4;
    localparam int ADDR_WID     = 6;

    localparam int META_WID     = 8;
    // Packet length in bytes, up to 512
    localparam int SIZE_WID     = 10;
    localparam int BUF_SIZE_WID = 5;

    // --------------------
    // Memory and queue sizing
    // --------------------
    localparam int MEM_RD_LATENCY  = 2;
    // Covers the read latency plus two words of slack
    localparam int PREFETCH_DEPTH  = MEM_RD_LATENCY + 2;
    localparam int BUF_QUEUE_DEPTH = 4;

    // --------------------
    // Structs
    // --------------------
    typedef struct packed {
        logic [PTR_WID-1:0]  ptr;
        logic [SIZE_WID-1:0] size;
        logic [META_WID-1:0] meta;
    } desc_t;

    // Size 0 on the eof buffer means the buffer is full
    typedef struct packed {
        logic [PTR_WID-1:0]      ptr;
        logic                    eof;
        logic [BUF_SIZE_WID-1:0] size;
        logic [META_WID-1:0]     meta;
    } buffer_ctxt_t;

    typedef struct packed {
        logic                eop;
        logic [MTY_WID-1:0]  mty;
        logic [META_WID-1:0] meta;
    } rd_ctxt_t;

    typedef struct packed {
        logic [DATA_WID-1:0] data;
        logic                eop;
        logic [MTY_WID-1:0]  mty;
        logic [META_WID-1:0] meta;
    } pkt_word_t;

    typedef struct packed {
        logic [META_WID-1:0] meta;
        logic [SIZE_WID-1:0] size;
    } pkt_event_t;

endpackage

`default_nettype wire

// File: source/gather_top.sv
// Packet gather subsystem top

`timescale 1ns/100ps
`default_nettype none

module gather_top (
    input  logic                             clk,
    input  logic                             srst,

    // Descriptors
    input  logic                             desc_vld,
    input  gather_pkg::desc_t                desc,
    output logic                             desc_rdy,

    // Link table load
    input  logic                             link_wr,
    input  logic [gather_pkg::PTR_WID-1:0]   link_ptr,
    input  logic [gather_pkg::PTR_WID-1:0]   link_nxt,

    // Memory load
    input  logic                             mem_wr,
    input  logic [gather_pkg::ADDR_WID-1:0]  mem_wr_addr,
    input  logic [gather_pkg::DATA_WID-1:0]  mem_wr_data,

    // Packet stream
    output logic                             pkt_vld,
    output gather_pkg::pkt_word_t            pkt,
    input  logic                             pkt_rdy,

    // Completion event
    output logic                             evt,
    output gather_pkg::pkt_event_t           evt_info
);

    logic                            buf_wr;
    gather_pkg::buffer_ctxt_t        buf_ctxt;
    logic                            buf_space;

    logic                            mem_rd_req;
    logic [gather_pkg::ADDR_WID-1:0] mem_rd_addr;
    logic                            mem_rd_ack;
    logic [gather_pkg::DATA_WID-1:0] mem_rd_data;

    buffer_chain i_buffer_chain (
        .clk       (clk),
        .srst      (srst),
        .desc_vld  (desc_vld),
        .desc      (desc),
        .desc_rdy  (desc_rdy),
        .link_wr   (link_wr),
        .link_ptr  (link_ptr),
        .link_nxt  (link_nxt),
        .buf_wr    (buf_wr),
        .buf_ctxt  (buf_ctxt),
        .buf_space (buf_space)
    );

    packet_gather i_packet_gather (
        .clk         (clk),
        .srst        (srst),
        .buf_wr      (buf_wr),
        .buf_ctxt    (buf_ctxt),
        .buf_space   (buf_space),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_ack  (mem_rd_ack),
        .mem_rd_data (mem_rd_data),
        .pkt_vld     (pkt_vld),
        .pkt         (pkt),
        .pkt_rdy     (pkt_rdy),
        .evt         (evt),
        .evt_info    (evt_info)
    );

    pkt_mem i_pkt_mem (
        .clk         (clk),
        .srst        (srst),
        .mem_wr      (mem_wr),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_ack  (mem_rd_ack),
        .mem_rd_data (mem_rd_data)
    );

endmodule

`default_nettype wire

// File: source/packet_gather.sv
// Packet gather engine
// Buffer reads, prefetch and packet output

`timescale 1ns/100ps
`default_nettype none

module packet_gather (
    input  logic                             clk,
    input  logic                             srst,

    // Buffer queue input
    input  logic                             buf_wr,
    input  gather_pkg::buffer_ctxt_t         buf_ctxt,
    output logic                             buf_space,

    // Memory read port
    output logic                             mem_rd_req,
    output logic [gather_pkg::ADDR_WID-1:0]  mem_rd_addr,
    input  logic                             mem_rd_ack,
    input  logic [gather_pkg::DATA_WID-1:0]  mem_rd_data,

    // Packet stream
    output logic                             pkt_vld,
    output gather_pkg::pkt_word_t            pkt,
    input  logic                             pkt_rdy,

    // Completion event
    output logic                             evt,
    output gather_pkg::pkt_event_t           evt_info
);

    gather_pkg::buffer_ctxt_t  head;
    logic                      bq_full;
    logic                      bq_empty;
    logic                      head_vld;

    logic                      rd_mob;
    logic                      nxt_rd_mob;
    logic                      rd_issue;
    logic                      buf_pop;
    logic                      rd_rdy;
    logic                      rd_eop;
    logic                      rd_last;
    logic [gather_pkg::MTY_WID-1:0] rd_mty;

    logic [$clog2(gather_pkg::BUFFER_WORDS)-1:0]   words;
    logic [gather_pkg::BUF_SIZE_WID-1:0]           size_m1;
    logic [$clog2(gather_pkg::PREFETCH_DEPTH+1)-1:0] ctxt_count;
    logic [$clog2(gather_pkg::PREFETCH_DEPTH+1)-1:0] pf_count;
    logic [$clog2(gather_pkg::PREFETCH_DEPTH+1):0]   inflight;

    gather_pkg::rd_ctxt_t      rd_ctxt_in;
    gather_pkg::rd_ctxt_t      rd_ctxt_out;
    gather_pkg::pkt_word_t     pf_wr_data;
    logic                      pf_empty;
    logic                      pkt_xfer;

    logic [gather_pkg::SIZE_WID-1:0] byte_cnt;
    logic [gather_pkg::SIZE_WID-1:0] word_bytes;

    // --------------------
    // Buffer queue
    // --------------------
    fifo_sync #(
        .WIDTH ($bits(gather_pkg::buffer_ctxt_t)),
        .DEPTH (gather_pkg::BUF_QUEUE_DEPTH)
    ) i_fifo_buf (
        .clk     (clk),
        .srst    (srst),
        .wr      (buf_wr),
        .wr_data (buf_ctxt),
        .full    (bq_full),
        .count   (),
        .rd      (buf_pop),
        .rd_data (head),
        .empty   (bq_empty)
    );

    assign buf_space = !bq_full;
    assign head_vld  = !bq_empty;

    // Words held in prefetch plus reads still in flight
    assign inflight = {1'b0, ctxt_count} + {1'b0, pf_count};
    assign rd_rdy   = (inflight < gather_pkg::PREFETCH_DEPTH);

    // --------------------
    // Read FSM, start / middle of buffer
    // --------------------
    always_comb begin
        nxt_rd_mob = rd_mob;
        rd_issue   = 1'b0;
        buf_pop    = 1'b0;
        if (!rd_mob) begin
            if (head_vld && rd_rdy) begin
                rd_issue = 1'b1;
                if (rd_last) buf_pop = 1'b1;
                else nxt_rd_mob = 1'b1;
            end
        end else begin
            if (rd_rdy) begin
                rd_issue = 1'b1;
                if (rd_last) begin
                    buf_pop    = 1'b1;
                    nxt_rd_mob = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            rd_mob <= 1'b0;
            words  <= '0;
        end else begin
            rd_mob <= nxt_rd_mob;
            if (buf_pop) words <= '0;
            else if (rd_issue) words <= words + 1'b1;
        end
    end

    // eop falls on the word holding the last byte of the eof buffer
    // Size 0 wraps round to the last word of the buffer
    assign size_m1 = head.size - 1'b1;
    assign rd_eop  = head.eof
                  && (words == size_m1[gather_pkg::BUF_SIZE_WID-1:gather_pkg::MTY_WID]);

    assign rd_last = rd_eop || (words == gather_pkg::BUFFER_WORDS - 1);
    // Unused bytes in the final word, 0 when it is full
    assign rd_mty  = rd_eop ? ('0 - head.size[gather_pkg::MTY_WID-1:0]) : '0;

    assign mem_rd_req  = rd_issue;
    // ptr * BUFFER_WORDS + words
    assign mem_rd_addr = {head.ptr, words};

    // --------------------
    // Read context and prefetch
    // --------------------
    assign rd_ctxt_in.eop  = rd_eop;
    assign rd_ctxt_in.mty  = rd_mty;
    assign rd_ctxt_in.meta = head.meta;

    fifo_sync #(
        .WIDTH ($bits(gather_pkg::rd_ctxt_t)),
        .DEPTH (gather_pkg::PREFETCH_DEPTH)
    ) i_fifo_rd_ctxt (
        .clk     (clk),
        .srst    (srst),
        .wr      (rd_issue),
        .wr_data (rd_ctxt_in),
        .full    (),
        .count   (ctxt_count),
        .rd      (mem_rd_ack),
        .rd_data (rd_ctxt_out),
        .empty   ()
    );

    assign pf_wr_data.data = mem_rd_data;
    assign pf_wr_data.eop  = rd_ctxt_out.eop;
    assign pf_wr_data.mty  = rd_ctxt_out.mty;
    assign pf_wr_data.meta = rd_ctxt_out.meta;

    fifo_sync #(
        .WIDTH ($bits(gather_pkg::pkt_word_t)),
        .DEPTH (gather_pkg::PREFETCH_DEPTH)
    ) i_fifo_prefetch (
        .clk     (clk),
        .srst    (srst),
        .wr      (mem_rd_ack),
        .wr_data (pf_wr_data),
        .full    (),
        .count   (pf_count),
        .rd      (pkt_xfer),
        .rd_data (pkt),
        .empty   (pf_empty)
    );

    assign pkt_vld  = !pf_empty;
    assign pkt_xfer = pkt_vld && pkt_rdy;

    // --------------------
    // Packet length and event
    // --------------------
    assign word_bytes = gather_pkg::SIZE_WID'(gather_pkg::DATA_BYTES)
                      - gather_pkg::SIZE_WID'(pkt.mty);

    always_ff @(posedge clk) begin
        if (srst) begin
            byte_cnt <= '0;
        end else if (pkt_xfer) begin
            if (pkt.eop) byte_cnt <= '0;
            else byte_cnt <= byte_cnt + word_bytes;
        end
    end

    assign evt           = pkt_xfer && pkt.eop;
    assign evt_info.meta = pkt.meta;
    assign evt_info.size = byte_cnt + word_bytes;

endmodule

`default_nettype wire

// File: source/pkt_mem.sv
// Buffer memory, fixed read latency

`timescale 1ns/100ps
`default_nettype none

module pkt_mem (
    input  logic                             clk,
    input  logic                             srst,

    // Load port
    input  logic                             mem_wr,
    input  logic [gather_pkg::ADDR_WID-1:0]  mem_wr_addr,
    input  logic [gather_pkg::DATA_WID-1:0]  mem_wr_data,

    // Read port
    input  logic                             mem_rd_req,
    input  logic [gather_pkg::ADDR_WID-1:0]  mem_rd_addr,
    output logic                             mem_rd_ack,
    output logic [gather_pkg::DATA_WID-1:0]  mem_rd_data
);

    logic [gather_pkg::DATA_WID-1:0] mem      [2**gather_pkg::ADDR_WID];
    logic [gather_pkg::DATA_WID-1:0] rd_pipe  [gather_pkg::MEM_RD_LATENCY];
    logic                            ack_pipe [gather_pkg::MEM_RD_LATENCY];

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[mem_wr_addr] <= mem_wr_data;
        end
    end

    // Data pipeline
    always_ff @(posedge clk) begin
        rd_pipe[0] <= mem[mem_rd_addr];
        for (int i = 1; i < gather_pkg::MEM_RD_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    // Ack follows each request by the full latency
    always_ff @(posedge clk) begin
        if (srst) begin
            for (int i = 0; i < gather_pkg::MEM_RD_LATENCY; i++) begin
                ack_pipe[i] <= 1'b0;
            end
        end else begin
            ack_pipe[0] <= mem_rd_req;
            for (int i = 1; i < gather_pkg::MEM_RD_LATENCY; i++) begin
                ack_pipe[i] <= ack_pipe[i-1];
            end
        end
    end

    assign mem_rd_ack  = ack_pipe[gather_pkg::MEM_RD_LATENCY-1];
    assign mem_rd_data = rd_pipe[gather_pkg::MEM_RD_LATENCY-1];

endmodule

`default_nettype wire

// File: verilog.f
source/gather_pkg.sv
source/fifo_sync.sv
source/buffer_chain.sv
source/packet_gather.sv
source/pkt_mem.sv
source/gather_top.sv
sim/clk_gen.sv
sim/gather_tb.sv
